// File: src/nnPkg.sv
package nnPkg;

	localparam int SampleW = 8;
	localparam int WeightW = 8;
	localparam int AccumW = 24;
	localparam int ClassW = 2;

	typedef logic [SampleW-1:0] sampleT;
	typedef logic signed [WeightW-1:0] weightT;
	typedef logic signed [AccumW-1:0] accumT;
	typedef logic [ClassW-1:0] classT;

	localparam int NumInputs = 15;
	localparam int NumHidden = 4;
	localparam int NumClasses = 3;

	// Activation clamp.
	localparam int SatLimit = 8192;
	localparam int ActShift = 5;
	localparam int ActMax = 255;

	//////////////////////////////////////////////////////////////////////
	// Default weights, listed from the highest slot down.
	// Slot of neuron n, input i is n * inputs + i.
	//////////////////////////////////////////////////////////////////////
	localparam logic [NumHidden*NumInputs*WeightW-1:0] HiddenWeightsDefault = {
		8'sd5, -8'sd7, 8'sd11, 8'sd3, -8'sd2, 8'sd9, -8'sd6, 8'sd14,
		-8'sd1, 8'sd8, -8'sd12, 8'sd4, 8'sd7, -8'sd3, 8'sd10,
		-8'sd4, 8'sd12, 8'sd6, -8'sd9, 8'sd15, 8'sd2, -8'sd5, 8'sd3,
		8'sd11, -8'sd8, 8'sd1, 8'sd13, -8'sd2, 8'sd6, -8'sd7,
		8'sd9, 8'sd3, -8'sd11, 8'sd7, 8'sd4, -8'sd6, 8'sd17, -8'sd3,
		8'sd2, 8'sd10, -8'sd5, 8'sd8, -8'sd14, 8'sd5, 8'sd12,
		8'sd16, 8'sd18, -8'sd3, 8'sd10, -8'sd9, -8'sd1, 8'sd4, 8'sd12,
		8'sd1, -8'sd24, 8'sd22, 8'sd13, -8'sd4, -8'sd10, 8'sd16
	};
	localparam logic [NumHidden*AccumW-1:0] HiddenBiasDefault = {
		24'sd40, -24'sd100, 24'sd25, -24'sd1
	};
	localparam logic [NumClasses*NumHidden*WeightW-1:0] OutWeightsDefault = {
		8'sd7, -8'sd4, 8'sd10, 8'sd2,
		-8'sd5, 8'sd12, 8'sd3, 8'sd6,
		8'sd11, 8'sd2, -8'sd7, 8'sd8
	};
	localparam logic [NumClasses*AccumW-1:0] OutBiasDefault = {
		-24'sd30, 24'sd15, 24'sd0
	};

endpackage

// File: src/sampleLoader.sv
`timescale 1ns/1ps

module sampleLoader (
	input logic clk,
	input logic reset,
	input logic sampleStrobe,
	input nnPkg::sampleT sampleData,
	output logic vecStrobe,
	output logic [nnPkg::NumInputs*nnPkg::SampleW-1:0] vecData
);

	localparam int CountW = $clog2(nnPkg::NumInputs);
	localparam int BufW = (nnPkg::NumInputs - 1) * nnPkg::SampleW;

	logic [CountW-1:0] posCount;
	logic [BufW-1:0] sampleBuf;
	logic lastSample;

	assign lastSample = (posCount == CountW'(nnPkg::NumInputs - 1));

	// Slot position of the next sample.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			posCount <= '0;
		end
		else if (sampleStrobe)
		begin
			if (lastSample)
				posCount <= '0;
			else
				posCount <= posCount + 1'b1;
		end
	end

	// Last sample goes straight to the top slot of the output.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sampleBuf <= '0;
			vecData <= '0;
			vecStrobe <= 1'b0;
		end
		else
		begin
			vecStrobe <= sampleStrobe && lastSample;
			if (sampleStrobe && lastSample)
				vecData <= {sampleData, sampleBuf};
			else if (sampleStrobe)
				sampleBuf[posCount*nnPkg::SampleW +: nnPkg::SampleW] <= sampleData;
		end
	end

endmodule

// File: src/neuronNode.sv
`timescale 1ns/1ps

module neuronNode #(
	parameter int NumIn = nnPkg::NumInputs,
	parameter logic [NumIn*nnPkg::WeightW-1:0] Weights = '0,
	parameter nnPkg::accumT Bias = '0
) (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input logic [NumIn*nnPkg::SampleW-1:0] inData,
	output logic outStrobe,
	output nnPkg::sampleT outData
);

	logic [NumIn*nnPkg::SampleW-1:0] inReg;
	nnPkg::accumT sumNext;
	nnPkg::accumT sumReg;
	logic inStrobeReg;
	logic sumStrobe;

	//////////////////////////////////////////////////////////////////////
	// Stage 1. Input capture.
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
			inStrobeReg <= 1'b0;
		end
		else
		begin
			inReg <= inData;
			inStrobeReg <= inStrobe;
		end
	end

	// Products wrap at the accumulator width.
	always_comb
	begin
		sumNext = Bias;
		for (int i = 0; i < NumIn; i++)
		begin
			sumNext = sumNext
				+ nnPkg::accumT'(inReg[i*nnPkg::SampleW +: nnPkg::SampleW])
				* nnPkg::accumT'(nnPkg::weightT'(Weights[i*nnPkg::WeightW +: nnPkg::WeightW]));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 2 and 3. Sum, then clamped activation.
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			sumStrobe <= 1'b0;
			outData <= '0;
			outStrobe <= 1'b0;
		end
		else
		begin
			sumReg <= sumNext;
			sumStrobe <= inStrobeReg;
			outStrobe <= sumStrobe;
			if (sumReg < 0)
				outData <= '0;
			else if (sumReg >= nnPkg::accumT'(nnPkg::SatLimit))
				outData <= nnPkg::sampleT'(nnPkg::ActMax);
			else
				outData <= nnPkg::sampleT'(sumReg >>> nnPkg::ActShift);
		end
	end

endmodule

// File: src/denseLayer.sv
`timescale 1ns/1ps

module denseLayer #(
	parameter int NumIn = nnPkg::NumInputs,
	parameter int NumOut = nnPkg::NumHidden,
	parameter logic [NumOut*NumIn*nnPkg::WeightW-1:0] Weights = '0,
	parameter logic [NumOut*nnPkg::AccumW-1:0] Biases = '0
) (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input logic [NumIn*nnPkg::SampleW-1:0] inData,
	output logic outStrobe,
	output logic [NumOut*nnPkg::SampleW-1:0] outData
);

	localparam int RowW = NumIn * nnPkg::WeightW;

	logic [NumOut-1:0] nodeStrobe;

	//////////////////////////////////////////////////////////////////////
	// One neuron per output, each with its own weight row.
	//////////////////////////////////////////////////////////////////////
	for (genvar n = 0; n < NumOut; n++)
	begin : gNode
		neuronNode #(
			.NumIn(NumIn),
			.Weights(Weights[n*RowW +: RowW]),
			.Bias(nnPkg::accumT'(Biases[n*nnPkg::AccumW +: nnPkg::AccumW]))
		) node (
			.clk(clk),
			.reset(reset),
			.inStrobe(inStrobe),
			.inData(inData),
			.outStrobe(nodeStrobe[n]),
			.outData(outData[n*nnPkg::SampleW +: nnPkg::SampleW])
		);
	end

	// All neurons share one latency.
	assign outStrobe = nodeStrobe[0];

endmodule

// File: src/argmaxSelect.sv
`timescale 1ns/1ps

module argmaxSelect #(
	parameter int NumIn = nnPkg::NumClasses
) (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input logic [NumIn*nnPkg::SampleW-1:0] inData,
	output logic classStrobe,
	output nnPkg::classT classIndex,
	output nnPkg::sampleT classScore
);

	nnPkg::classT bestIdx;
	nnPkg::sampleT bestVal;

	// Strict compare keeps the lower index on a tie.
	always_comb
	begin
		bestIdx = '0;
		bestVal = inData[0 +: nnPkg::SampleW];
		for (int i = 1; i < NumIn; i++)
		begin
			if (inData[i*nnPkg::SampleW +: nnPkg::SampleW] > bestVal)
			begin
				bestIdx = nnPkg::classT'(i);
				bestVal = inData[i*nnPkg::SampleW +: nnPkg::SampleW];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classStrobe <= 1'b0;
			classIndex <= '0;
			classScore <= '0;
		end
		else
		begin
			classStrobe <= inStrobe;
			if (inStrobe)
			begin
				classIndex <= bestIdx;
				classScore <= bestVal;
			end
		end
	end

endmodule

// File: src/nnClassifier.sv
`timescale 1ns/1ps

module nnClassifier #(
	parameter logic [nnPkg::NumHidden*nnPkg::NumInputs*nnPkg::WeightW-1:0] HiddenWeights =
		nnPkg::HiddenWeightsDefault,
	parameter logic [nnPkg::NumHidden*nnPkg::AccumW-1:0] HiddenBias =
		nnPkg::HiddenBiasDefault,
	parameter logic [nnPkg::NumClasses*nnPkg::NumHidden*nnPkg::WeightW-1:0] OutWeights =
		nnPkg::OutWeightsDefault,
	parameter logic [nnPkg::NumClasses*nnPkg::AccumW-1:0] OutBias =
		nnPkg::OutBiasDefault
) (
	input logic clk,
	input logic reset,
	input logic sampleStrobe,
	input nnPkg::sampleT sampleData,
	output logic classStrobe,
	output nnPkg::classT classIndex,
	output nnPkg::sampleT classScore
);

	logic vecStrobe;
	logic [nnPkg::NumInputs*nnPkg::SampleW-1:0] vecData;
	logic hidStrobe;
	logic [nnPkg::NumHidden*nnPkg::SampleW-1:0] hidData;
	logic outStrobe;
	logic [nnPkg::NumClasses*nnPkg::SampleW-1:0] outData;

	//////////////////////////////////////////////////////////////////////
	// Loader, hidden layer, output layer, argmax.
	//////////////////////////////////////////////////////////////////////
	sampleLoader loader (
		.clk(clk),
		.reset(reset),
		.sampleStrobe(sampleStrobe),
		.sampleData(sampleData),
		.vecStrobe(vecStrobe),
		.vecData(vecData)
	);

	denseLayer #(
		.NumIn(nnPkg::NumInputs),
		.NumOut(nnPkg::NumHidden),
		.Weights(HiddenWeights),
		.Biases(HiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inStrobe(vecStrobe),
		.inData(vecData),
		.outStrobe(hidStrobe),
		.outData(hidData)
	);

	denseLayer #(
		.NumIn(nnPkg::NumHidden),
		.NumOut(nnPkg::NumClasses),
		.Weights(OutWeights),
		.Biases(OutBias)
	) outLayer (
		.clk(clk),
		.reset(reset),
		.inStrobe(hidStrobe),
		.inData(hidData),
		.outStrobe(outStrobe),
		.outData(outData)
	);

	argmaxSelect #(
		.NumIn(nnPkg::NumClasses)
	) argmax (
		.clk(clk),
		.reset(reset),
		.inStrobe(outStrobe),
		.inData(outData),
		.classStrobe(classStrobe),
		.classIndex(classIndex),
		.classScore(classScore)
	);

endmodule

// File: verif/nnClassifierTb.sv
`timescale 1ns/1ps

module nnClassifierTb;

	localparam int ClkPeriod = 40;
	localparam int NumIn = nnPkg::NumInputs;
	localparam int NumHid = nnPkg::NumHidden;
	localparam int NumOut = nnPkg::NumClasses;
	localparam int WeightW = nnPkg::WeightW;
	localparam int AccumW = nnPkg::AccumW;
	localparam int LatencyCycles = 8;
	localparam int RandomVectors = 20;
	localparam int GapVectors = 5;
	localparam int MaxGap = 2;
	localparam int NumVectors = 3 + RandomVectors + GapVectors;
	localparam int WatchdogCycles = NumVectors * 20 + GapVectors * (NumIn - 1) * MaxGap + 200;

	// Reference copy of the default network.
	localparam logic [NumHid*NumIn*WeightW-1:0] HidW = nnPkg::HiddenWeightsDefault;
	localparam logic [NumHid*AccumW-1:0] HidB = nnPkg::HiddenBiasDefault;
	localparam logic [NumOut*NumHid*WeightW-1:0] OutW = nnPkg::OutWeightsDefault;
	localparam logic [NumOut*AccumW-1:0] OutB = nnPkg::OutBiasDefault;

	logic clk;
	logic reset;
	logic sampleStrobe;
	nnPkg::sampleT sampleData;
	logic classStrobe;
	nnPkg::classT classIndex;
	nnPkg::sampleT classScore;

	int vecBuf[NumIn];
	int expIdx[$];
	int expScore[$];
	int gotIdx[$];
	int gotScore[$];
	int gotEdge[$];
	int edgeCount = 0;
	int lastSendEdge = 0;
	int checkCount;
	int errorCount;

	nnClassifier UUT (
		.clk(clk),
		.reset(reset),
		.sampleStrobe(sampleStrobe),
		.sampleData(sampleData),
		.classStrobe(classStrobe),
		.classIndex(classIndex),
		.classScore(classScore)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	always @(posedge clk)
		edgeCount <= edgeCount + 1;

	// Results are taken mid-cycle, away from the rising edge.
	always @(negedge clk)
	begin
		if (classStrobe === 1'b1)
		begin
			gotIdx.push_back(int'(classIndex));
			gotScore.push_back(int'(classScore));
			gotEdge.push_back(edgeCount);
		end
	end

	initial
	begin
		#(WatchdogCycles * ClkPeriod);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WatchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model.
	//////////////////////////////////////////////////////////////////////
	function automatic int activate(input int sum);
		int wrapped;
		// 24-bit wrap.
		wrapped = (sum <<< 8) >>> 8;
		if (wrapped < 0)
			return 0;
		else if (wrapped >= nnPkg::SatLimit)
			return nnPkg::ActMax;
		return wrapped >>> nnPkg::ActShift;
	endfunction

	function automatic void modelClass(output int idx, output int score);
		int hid[NumHid];
		int outAct[NumOut];
		int sum;
		int w;
		for (int n = 0; n < NumHid; n++)
		begin
			sum = int'($signed(HidB[n*AccumW +: AccumW]));
			for (int i = 0; i < NumIn; i++)
			begin
				w = int'($signed(HidW[(n*NumIn+i)*WeightW +: WeightW]));
				sum += vecBuf[i] * w;
			end
			hid[n] = activate(sum);
		end
		for (int c = 0; c < NumOut; c++)
		begin
			sum = int'($signed(OutB[c*AccumW +: AccumW]));
			for (int n = 0; n < NumHid; n++)
			begin
				w = int'($signed(OutW[(c*NumHid+n)*WeightW +: WeightW]));
				sum += hid[n] * w;
			end
			outAct[c] = activate(sum);
		end
		// Lowest index wins a tie.
		idx = 0;
		score = outAct[0];
		for (int c = 1; c < NumOut; c++)
		begin
			if (outAct[c] > score)
			begin
				idx = c;
				score = outAct[c];
			end
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Drive, wait and compare.
	//////////////////////////////////////////////////////////////////////
	task automatic checkValue(input string name, input string what,
		input int expected, input int actual);
		checkCount++;
		if (expected != actual)
		begin
			$display("Fail %s %s: expected %0d, actual %0d", name, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic idleCycles(input int count);
		repeat (count)
		begin
			@(negedge clk);
			sampleStrobe = 1'b0;
		end
	endtask

	task automatic sendVector(input int maxGap);
		int idx;
		int score;
		int gap;
		modelClass(idx, score);
		expIdx.push_back(idx);
		expScore.push_back(score);
		for (int i = 0; i < NumIn; i++)
		begin
			@(negedge clk);
			sampleStrobe = 1'b1;
			sampleData = nnPkg::sampleT'(vecBuf[i]);
			lastSendEdge = edgeCount;
			if (i < NumIn - 1)
			begin
				gap = int'($urandom_range(maxGap, 0));
				repeat (gap)
				begin
					@(negedge clk);
					sampleStrobe = 1'b0;
					sampleData = nnPkg::sampleT'($urandom_range(255, 0));
				end
			end
		end
	endtask

	task automatic waitResults(input string name);
		int waited;
		@(negedge clk);
		sampleStrobe = 1'b0;
		waited = 0;
		while (gotIdx.size() < expIdx.size() && waited < LatencyCycles + 4)
		begin
			@(posedge clk);
			waited++;
		end
		if (gotIdx.size() < expIdx.size())
		begin
			$display("%s: only %0d of %0d class strobes arrived in time", name,
				gotIdx.size(), expIdx.size());
			errorCount++;
		end
	endtask

	task automatic compareResults(input string name);
		while (expIdx.size() > 0 && gotIdx.size() > 0)
		begin
			checkValue(name, "classIndex", expIdx.pop_front(), gotIdx.pop_front());
			checkValue(name, "classScore", expScore.pop_front(), gotScore.pop_front());
			void'(gotEdge.pop_front());
		end
		if (gotIdx.size() > 0)
		begin
			$display("%s: %0d class strobes came without a vector", name, gotIdx.size());
			errorCount++;
		end
		expIdx.delete();
		expScore.delete();
		gotIdx.delete();
		gotScore.delete();
		gotEdge.delete();
	endtask

	task automatic reportTest(input string name, input int startErrors);
		if (errorCount == startErrors)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errorCount - startErrors);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests.
	//////////////////////////////////////////////////////////////////////
	task automatic resetQuiet();
		int startErrors;
		startErrors = errorCount;
		idleCycles(20);
		checkValue("resetQuiet", "class strobes", 0, gotIdx.size());
		compareResults("resetQuiet");
		reportTest("resetQuiet", startErrors);
	endtask

	task automatic fixedLatency();
		int startErrors;
		startErrors = errorCount;
		for (int i = 0; i < NumIn; i++)
			vecBuf[i] = (i * 17 + 9) % 256;
		sendVector(0);
		waitResults("fixedLatency");
		if (gotEdge.size() > 0)
			checkValue("fixedLatency", "latency", LatencyCycles, gotEdge[0] - lastSendEdge);
		compareResults("fixedLatency");
		reportTest("fixedLatency", startErrors);
	endtask

	task automatic clampExtremes();
		int startErrors;
		startErrors = errorCount;
		for (int i = 0; i < NumIn; i++)
			vecBuf[i] = 0;
		sendVector(0);
		for (int i = 0; i < NumIn; i++)
			vecBuf[i] = 255;
		sendVector(0);
		waitResults("clampExtremes");
		compareResults("clampExtremes");
		reportTest("clampExtremes", startErrors);
	endtask

	task automatic randomBackToBack();
		int startErrors;
		startErrors = errorCount;
		for (int v = 0; v < RandomVectors; v++)
		begin
			for (int i = 0; i < NumIn; i++)
				vecBuf[i] = int'($urandom_range(255, 0));
			sendVector(0);
		end
		waitResults("randomBackToBack");
		compareResults("randomBackToBack");
		reportTest("randomBackToBack", startErrors);
	endtask

	task automatic gappedSamples();
		int startErrors;
		startErrors = errorCount;
		for (int v = 0; v < GapVectors; v++)
		begin
			for (int i = 0; i < NumIn; i++)
				vecBuf[i] = int'($urandom_range(255, 0));
			sendVector(MaxGap);
		end
		waitResults("gappedSamples");
		compareResults("gappedSamples");
		reportTest("gappedSamples", startErrors);
	endtask

	initial
	begin
		void'($urandom(29023));
		reset = 1'b1;
		sampleStrobe = 1'b0;
		sampleData = '0;
		checkCount = 0;
		errorCount = 0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		resetQuiet();
		fixedLatency();
		clampExtremes();
		randomBackToBack();
		gappedSamples();
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: nnClassifier.f
src/nnPkg.sv
src/sampleLoader.sv
src/neuronNode.sv
src/denseLayer.sv
src/argmaxSelect.sv
src/nnClassifier.sv
verif/nnClassifierTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing -Wno-fatal \
	-f nnClassifier.f \
	--top-module nnClassifierTb \
	-Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/simv" > "$LOG_FILE" 2>&1
runStatus=$?
cat "$LOG_FILE"
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

# Verdict comes from the log.
if grep -q "CHECKS FAILED" "$LOG_FILE"; then
	echo "Simulation reported failures"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
